//--- project.f
+incdir+source
source/lsc_pkg.sv
source/lsc_addr_map.sv
source/lsc_issue.sv
source/lsc_pipe_stage.sv
source/lsc_retire.sv
source/lsc_ctl_top.sv
verification/lsc_chk.sv
verification/lsc_tb.sv

//--- source/lsc_addr_map.sv
// Address map: DCCM, PIC and external classification with misaligned and access faults
`timescale 1ns/100ps
`default_nettype none

`include "lsc_consts.svh"

module lsc_addr_map (
  input  logic [`LSC_XLEN-1:0] start_addr,
  input  logic [`LSC_XLEN-1:0] end_addr,
  input  lsc_pkg::lsu_size_e   size,
  output logic                 in_dccm,
  output logic                 in_pic,
  output logic                 external,
  output logic                 misaligned,
  output logic                 access_fault
);

  logic end_in_dccm;
  logic end_in_pic;
  logic unaligned;

  // True when addr lies in [base, base + size)
  function automatic logic in_window(
    input logic [`LSC_XLEN-1:0] addr,
    input logic [`LSC_XLEN-1:0] base,
    input logic [`LSC_XLEN-1:0] win_size
  );
    in_window = (addr >= base) && (addr < base + win_size);
  endfunction

  // Region follows the start address
  assign in_dccm  = in_window(start_addr, `LSC_DCCM_BASE, `LSC_DCCM_SIZE);
  assign in_pic   = in_window(start_addr, `LSC_PIC_BASE, `LSC_PIC_SIZE);
  assign external = ~in_dccm & ~in_pic;

  assign end_in_dccm = in_window(end_addr, `LSC_DCCM_BASE, `LSC_DCCM_SIZE);
  assign end_in_pic  = in_window(end_addr, `LSC_PIC_BASE, `LSC_PIC_SIZE);

  // Natural alignment check per size
  always_comb begin
    case (size)
      lsc_pkg::sz_half: unaligned = start_addr[0];
      lsc_pkg::sz_word: unaligned = |start_addr[1:0];
      default:          unaligned = 1'b0;
    endcase
  end

  // DCCM handles unaligned accesses itself
  assign misaligned = unaligned & ~in_dccm;

  // Crossing a region boundary, or a PIC access narrower than a word
  assign access_fault = (end_in_dccm != in_dccm) |
                        (end_in_pic != in_pic) |
                        (in_pic & (size != lsc_pkg::sz_word));

endmodule

`default_nettype wire

//--- source/lsc_consts.svh
// Width, pipe depth and memory-map macros for the load/store control pipeline

`ifndef LSC_CONSTS_SVH
`define LSC_CONSTS_SVH

// **********************************************************************
// Datapath widths
// **********************************************************************

// Data and address width
`define LSC_XLEN 32

// Immediate offset carried with a core request
`define LSC_OFFSET_W 12

// Register stages dc1 through dc5
`define LSC_DEPTH 5

// **********************************************************************
// Memory map
// **********************************************************************

// DCCM window, 64 KB
`define LSC_DCCM_BASE 32'hF004_0000
`define LSC_DCCM_SIZE 32'h0001_0000

// PIC window, 32 KB
`define LSC_PIC_BASE 32'hF00C_0000
`define LSC_PIC_SIZE 32'h0000_8000

`endif

//--- source/lsc_ctl_top.sv
// Load/store control top: issue, dc1 to dc5 stage chain and retire
`timescale 1ns/100ps
`default_nettype none

`include "lsc_consts.svh"

module lsc_ctl_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  lsc_pkg::lsu_issue_t     issue,
  input  lsc_pkg::dma_req_t       dma,
  input  lsc_pkg::lsu_flush_t     flush,
  input  logic [`LSC_XLEN-1:0]    ld_data_dc3,
  input  logic [`LSC_XLEN-1:0]    bus_read_data_dc3,
  input  logic                    ld_bus_error_dc3,
  output logic [`LSC_XLEN-1:0]    lsu_addr_dc1,
  output logic [`LSC_XLEN-1:0]    lsu_result_dc3,
  output logic                    lsu_exc_dc2,
  output lsc_pkg::lsu_error_pkt_t lsu_error_pkt_dc3,
  output logic                    lsu_commit_dc5,
  output logic [`LSC_XLEN-1:0]    lsu_addr_dc5,
  output logic [`LSC_XLEN-1:0]    store_data_dc5
);

  // chain[0] is the issue packet, chain[k+1] is the live output of stage k
  lsc_pkg::lsu_pkt_t    chain [`LSC_DEPTH+1];
  lsc_pkg::lsu_pkt_t    stage_pkt [`LSC_DEPTH];
  logic [`LSC_DEPTH-1:0] kill;

  // Kill per stage, dc1 and dc2 share the dc2-and-up flush
  assign kill = {flush.flush_dc5, flush.flush_dc4, flush.flush_dc3,
                 flush.flush_dc2_up, flush.flush_dc2_up};

  lsc_issue u_issue (
    .issue       (issue),
    .dma         (dma),
    .flush_dc2_up(flush.flush_dc2_up),
    .pkt_d       (chain[0])
  );

  // **********************************************************************
  // dc1 .. dc5 register chain
  // **********************************************************************

  for (genvar k = 0; k < `LSC_DEPTH; k++) begin : g_stage
    lsc_pipe_stage u_stage (
      .clk     (clk),
      .rst_n   (rst_n),
      .pkt_in  (chain[k]),
      .kill    (kill[k]),
      .pkt     (stage_pkt[k]),
      .pkt_live(chain[k+1])
    );
  end

  assign lsu_addr_dc1 = stage_pkt[0].addr;

  lsc_retire u_retire (
    .pkt_dc2          (stage_pkt[1]),
    .pkt_dc3          (stage_pkt[2]),
    .live_dc3         (chain[3]),
    .live_dc5         (chain[`LSC_DEPTH]),
    .ld_data_dc3      (ld_data_dc3),
    .bus_read_data_dc3(bus_read_data_dc3),
    .ld_bus_error_dc3 (ld_bus_error_dc3),
    .lsu_result_dc3   (lsu_result_dc3),
    .lsu_addr_dc5     (lsu_addr_dc5),
    .store_data_dc5   (store_data_dc5),
    .lsu_exc_dc2      (lsu_exc_dc2),
    .lsu_commit_dc5   (lsu_commit_dc5),
    .lsu_error_pkt_dc3(lsu_error_pkt_dc3)
  );

endmodule

`default_nettype wire

//--- source/lsc_issue.sv
// Issue stage: DMA premux, address generation, size decode, store data and initial packet
`timescale 1ns/100ps
`default_nettype none

`include "lsc_consts.svh"

module lsc_issue (
  input  lsc_pkg::lsu_issue_t issue,
  input  lsc_pkg::dma_req_t   dma,
  input  logic                flush_dc2_up,
  output lsc_pkg::lsu_pkt_t   pkt_d
);

  logic [`LSC_XLEN-1:0]     base_addr;
  logic [`LSC_OFFSET_W-1:0] offset;
  logic [`LSC_XLEN-1:0]     start_addr;
  logic [`LSC_XLEN-1:0]     end_addr;
  logic [1:0]               last_byte;
  logic [`LSC_XLEN-1:0]     dma_wdata_shifted;
  logic [`LSC_XLEN-1:0]     store_data;
  lsc_pkg::lsu_size_e       dma_size;
  lsc_pkg::lsu_size_e       size;
  lsc_pkg::lsu_op_e         dma_op;
  logic                     in_dccm;
  logic                     in_pic;
  logic                     external;
  logic                     misaligned;
  logic                     access_fault;

  // **********************************************************************
  // DMA premux
  // **********************************************************************

  // DMA address goes in as rs1 with a zero offset
  assign base_addr = dma.req ? dma.addr : issue.rs1;
  assign offset    = dma.req ? '0 : issue.offset;

  // Size 3 and above collapse to a word
  always_comb begin
    case (dma.sz)
      3'd0:    dma_size = lsc_pkg::sz_byte;
      3'd1:    dma_size = lsc_pkg::sz_half;
      default: dma_size = lsc_pkg::sz_word;
    endcase
  end

  assign size   = dma.req ? dma_size : issue.size;
  assign dma_op = dma.write ? lsc_pkg::op_store : lsc_pkg::op_load;

  // **********************************************************************
  // Start and end address
  // **********************************************************************

  assign start_addr = base_addr +
                      {{(`LSC_XLEN-`LSC_OFFSET_W){offset[`LSC_OFFSET_W-1]}}, offset};

  // Offset of the last byte touched
  always_comb begin
    case (size)
      lsc_pkg::sz_byte: last_byte = 2'd0;
      lsc_pkg::sz_half: last_byte = 2'd1;
      default:          last_byte = 2'd3;
    endcase
  end

  assign end_addr = start_addr + {{(`LSC_XLEN-2){1'b0}}, last_byte};

  lsc_addr_map u_addr_map (
    .start_addr  (start_addr),
    .end_addr    (end_addr),
    .size        (size),
    .in_dccm     (in_dccm),
    .in_pic      (in_pic),
    .external    (external),
    .misaligned  (misaligned),
    .access_fault(access_fault)
  );

  // DMA write data is moved down to byte lane 0 like a core store
  assign dma_wdata_shifted = dma.wdata >> {dma.addr[1:0], 3'b000};
  assign store_data        = dma.req ? dma_wdata_shifted : issue.rs2;

  // **********************************************************************
  // Packet into dc1
  // **********************************************************************

  always_comb begin
    pkt_d.valid        = dma.req | (issue.valid & ~flush_dc2_up);
    pkt_d.dma          = dma.req;
    pkt_d.op           = dma.req ? dma_op : issue.op;
    pkt_d.size         = size;
    pkt_d.unsign       = ~dma.req & issue.unsign;
    pkt_d.addr         = start_addr;
    pkt_d.in_dccm      = in_dccm;
    pkt_d.in_pic       = in_pic;
    pkt_d.external     = external;
    pkt_d.misaligned   = misaligned;
    pkt_d.access_fault = access_fault;
    pkt_d.store_data   = store_data;
  end

endmodule

`default_nettype wire

//--- source/lsc_pipe_stage.sv
// One pipe register stage with flush kill of non-DMA entries
`timescale 1ns/100ps
`default_nettype none

module lsc_pipe_stage (
  input  logic              clk,
  input  logic              rst_n,
  input  lsc_pkg::lsu_pkt_t pkt_in,
  input  logic              kill,
  output lsc_pkg::lsu_pkt_t pkt,
  output lsc_pkg::lsu_pkt_t pkt_live
);

  logic              valid_q;
  lsc_pkg::lsu_pkt_t data_q;

  // Only valid is control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pkt_in.valid;
    end
  end

  always_ff @(posedge clk) begin
    data_q <= pkt_in;
  end

  always_comb begin
    pkt       = data_q;
    pkt.valid = valid_q;
  end

  // DMA entries ride through any flush
  always_comb begin
    pkt_live       = pkt;
    pkt_live.valid = valid_q & ~(kill & ~data_q.dma);
  end

endmodule

`default_nettype wire

//--- source/lsc_pkg.sv
// Opcode and size enums, request, flush, pipe packet and error packet structs
`default_nettype none

`include "lsc_consts.svh"

package lsc_pkg;

  typedef enum logic {
    op_load  = 1'b0,
    op_store = 1'b1
  } lsu_op_e;

  // Encoding follows the DMA size field for byte, half and word
  typedef enum logic [1:0] {
    sz_byte = 2'd0,
    sz_half = 2'd1,
    sz_word = 2'd2
  } lsu_size_e;

  // Core issue port
  typedef struct packed {
    logic                     valid;
    lsu_op_e                  op;
    lsu_size_e                size;
    logic                     unsign;
    logic [`LSC_XLEN-1:0]     rs1;
    logic [`LSC_OFFSET_W-1:0] offset;
    logic [`LSC_XLEN-1:0]     rs2;
  } lsu_issue_t;

  // DMA slave request, sz of 3 is handled as a word
  typedef struct packed {
    logic                 req;
    logic [`LSC_XLEN-1:0] addr;
    logic [2:0]           sz;
    logic                 write;
    logic [`LSC_XLEN-1:0] wdata;
  } dma_req_t;

  typedef struct packed {
    logic flush_dc2_up;
    logic flush_dc3;
    logic flush_dc4;
    logic flush_dc5;
  } lsu_flush_t;

  // Packet carried from dc1 down to dc5
  typedef struct packed {
    logic                 valid;
    logic                 dma;
    lsu_op_e              op;
    lsu_size_e            size;
    logic                 unsign;
    logic [`LSC_XLEN-1:0] addr;
    logic                 in_dccm;
    logic                 in_pic;
    logic                 external;
    logic                 misaligned;
    logic                 access_fault;
    logic [`LSC_XLEN-1:0] store_data;
  } lsu_pkt_t;

  // exc_type is 1 for access or bus fault, 0 for misaligned
  typedef struct packed {
    logic                 exc_valid;
    logic                 exc_type;
    logic                 inst_type;
    logic                 dma_valid;
    logic [`LSC_XLEN-1:0] addr;
  } lsu_error_pkt_t;

endpackage

`default_nettype wire

//--- source/lsc_retire.sv
// Retire: dc3 load result, dc2 exception, dc3 error packet and dc5 commit
`timescale 1ns/100ps
`default_nettype none

`include "lsc_consts.svh"

module lsc_retire (
  input  lsc_pkg::lsu_pkt_t       pkt_dc2,
  input  lsc_pkg::lsu_pkt_t       pkt_dc3,
  input  lsc_pkg::lsu_pkt_t       live_dc3,
  input  lsc_pkg::lsu_pkt_t       live_dc5,
  input  logic [`LSC_XLEN-1:0]    ld_data_dc3,
  input  logic [`LSC_XLEN-1:0]    bus_read_data_dc3,
  input  logic                    ld_bus_error_dc3,
  output logic [`LSC_XLEN-1:0]    lsu_result_dc3,
  output logic [`LSC_XLEN-1:0]    lsu_addr_dc5,
  output logic [`LSC_XLEN-1:0]    store_data_dc5,
  output logic                    lsu_exc_dc2,
  output logic                    lsu_commit_dc5,
  output lsc_pkg::lsu_error_pkt_t lsu_error_pkt_dc3
);

  logic [`LSC_XLEN-1:0] ld_datafn_dc3;
  logic                 fill_byte;
  logic                 fill_half;

  // **********************************************************************
  // dc3 load result
  // **********************************************************************

  // External loads return over the bus
  assign ld_datafn_dc3 = pkt_dc3.external ? bus_read_data_dc3 : ld_data_dc3;

  assign fill_byte = ~pkt_dc3.unsign & ld_datafn_dc3[7];
  assign fill_half = ~pkt_dc3.unsign & ld_datafn_dc3[15];

  always_comb begin
    case (pkt_dc3.size)
      lsc_pkg::sz_byte: lsu_result_dc3 = {{(`LSC_XLEN-8){fill_byte}}, ld_datafn_dc3[7:0]};
      lsc_pkg::sz_half: lsu_result_dc3 = {{(`LSC_XLEN-16){fill_half}}, ld_datafn_dc3[15:0]};
      default:          lsu_result_dc3 = ld_datafn_dc3;
    endcase
  end

  // **********************************************************************
  // Exceptions
  // **********************************************************************

  assign lsu_exc_dc2 = pkt_dc2.valid & (pkt_dc2.misaligned | pkt_dc2.access_fault);

  // A flushed dc3 entry reports nothing, so the live copy gates it
  assign lsu_error_pkt_dc3.exc_valid = live_dc3.valid & ~live_dc3.dma &
                                       (live_dc3.misaligned | live_dc3.access_fault |
                                        ld_bus_error_dc3);

  // Misaligned wins the type when both faults are present
  assign lsu_error_pkt_dc3.exc_type  = ~pkt_dc3.misaligned;
  assign lsu_error_pkt_dc3.inst_type = (pkt_dc3.op == lsc_pkg::op_store);
  assign lsu_error_pkt_dc3.dma_valid = pkt_dc3.valid & pkt_dc3.dma;
  assign lsu_error_pkt_dc3.addr      = pkt_dc3.addr;

  // **********************************************************************
  // dc5 commit
  // **********************************************************************

  // DMA traffic never writes back to the core
  assign lsu_commit_dc5 = live_dc5.valid & ~live_dc5.dma;

  assign lsu_addr_dc5   = live_dc5.addr;
  assign store_data_dc5 = live_dc5.store_data;

endmodule

`default_nettype wire

//--- verification/lsc_chk.sv
// Bound assertions on dc5 commit, dc3 exception and reset behavior of the control top
`timescale 1ns/100ps
`default_nettype none

module lsc_chk (
  input logic                clk,
  input logic                rst_n,
  input lsc_pkg::lsu_issue_t issue,
  input lsc_pkg::dma_req_t   dma,
  input lsc_pkg::lsu_flush_t flush,
  input logic                commit,
  input logic                exc_valid
);

  // Number of assertion failures so far
  int unsigned assert_fails = 0;

  // DMA traffic never retires to the core, traced back to the issue cycle
  a_no_dma_commit: assert property (@(posedge clk) disable iff (!rst_n)
    commit |-> !$past(dma.req, 5))
    else begin
      assert_fails++;
      $error("commit raised for a DMA request issued five cycles earlier");
    end

  // An error report needs a core access that got past issue three cycles earlier
  a_exc_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
    exc_valid |-> $past(issue.valid & ~dma.req & ~flush.flush_dc2_up, 3))
    else begin
      assert_fails++;
      $error("exc_valid raised without a core access issued three cycles earlier");
    end

  a_reset_commit: assert property (@(posedge clk) !rst_n |-> !commit)
    else begin
      assert_fails++;
      $error("commit raised while reset is asserted");
    end

endmodule

bind lsc_ctl_top lsc_chk u_chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .issue    (issue),
  .dma      (dma),
  .flush    (flush),
  .commit   (lsu_commit_dc5),
  .exc_valid(lsu_error_pkt_dc3.exc_valid)
);

`default_nettype wire

//--- verification/lsc_tb.sv
// Testbench for the load/store control pipeline: stimulus, reference model and checks
`timescale 1ns/100ps
`default_nettype none

`include "lsc_consts.svh"

module lsc_tb;

  localparam int N_CYC     = 336;
  localparam int N_MEM     = N_CYC + 8;
  localparam int LIMIT_CYC = N_CYC + 3 + 50;

  // Expected outputs for one issue slot
  typedef struct packed {
    logic [31:0] addr;
    logic        exc_dc2;
    logic        is_load;
    logic [31:0] result;
    logic        exc_valid;
    logic        exc_type;
    logic        inst_type;
    logic        dma_valid;
    logic        commit;
    logic        chk_dc5;
    logic [31:0] store_data;
  } exp_t;

  logic                    clk;
  logic                    rst_n;
  lsc_pkg::lsu_issue_t     issue;
  lsc_pkg::dma_req_t       dma;
  lsc_pkg::lsu_flush_t     flush;
  logic [31:0]             ld_data_dc3;
  logic [31:0]             bus_read_data_dc3;
  logic                    ld_bus_error_dc3;
  logic [31:0]             lsu_addr_dc1;
  logic [31:0]             lsu_result_dc3;
  logic                    lsu_exc_dc2;
  lsc_pkg::lsu_error_pkt_t lsu_error_pkt_dc3;
  logic                    lsu_commit_dc5;
  logic [31:0]             lsu_addr_dc5;
  logic [31:0]             store_data_dc5;

  // Stimulus and expectations, indexed by issue cycle
  lsc_pkg::lsu_issue_t iss_m [N_MEM];
  lsc_pkg::dma_req_t   dma_m [N_MEM];
  lsc_pkg::lsu_flush_t fl_m [N_MEM];
  logic [31:0]         ld_m [N_MEM];
  logic [31:0]         bus_m [N_MEM];
  logic                berr_m [N_MEM];
  exp_t                exp_m [N_MEM];

  integer seed;
  int     cyc;
  int     cycles = 0;
  int     n_checks;
  int     n_val_err;
  int     n_other_err;
  logic   running;
  exp_t   e1;
  exp_t   e2;
  exp_t   e3;
  exp_t   e5;

  lsc_ctl_top u_dut (
    .clk              (clk),
    .rst_n            (rst_n),
    .issue            (issue),
    .dma              (dma),
    .flush            (flush),
    .ld_data_dc3      (ld_data_dc3),
    .bus_read_data_dc3(bus_read_data_dc3),
    .ld_bus_error_dc3 (ld_bus_error_dc3),
    .lsu_addr_dc1     (lsu_addr_dc1),
    .lsu_result_dc3   (lsu_result_dc3),
    .lsu_exc_dc2      (lsu_exc_dc2),
    .lsu_error_pkt_dc3(lsu_error_pkt_dc3),
    .lsu_commit_dc5   (lsu_commit_dc5),
    .lsu_addr_dc5     (lsu_addr_dc5),
    .store_data_dc5   (store_data_dc5)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic int pick(input int n);
    pick = ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // **********************************************************************
  // Reference model
  // **********************************************************************

  // kv holds the kill seen at issue, dc1, dc2, dc3, dc4 and dc5
  function automatic exp_t model_access(
    input lsc_pkg::lsu_issue_t rq,
    input lsc_pkg::dma_req_t   dq,
    input logic [31:0]         ld,
    input logic [31:0]         bus,
    input logic                berr,
    input logic [5:0]          kv
  );
    exp_t        e;
    logic [31:0] a;
    logic [31:0] last;
    logic [31:0] raw;
    int          nb;
    int          sh;
    int          off;
    logic        core;
    logic        in_d;
    logic        in_p;
    logic        mis;
    logic        af;
    logic        unsg;
    e    = '0;
    core = rq.valid & ~dq.req;
    if (dq.req) begin
      a            = dq.addr;
      nb           = (dq.sz == 3'd0) ? 1 : ((dq.sz == 3'd1) ? 2 : 4);
      unsg         = 1'b0;
      e.inst_type  = dq.write;
      e.store_data = dq.wdata >> (8 * dq.addr[1:0]);
    end else begin
      off          = $signed(rq.offset);
      a            = rq.rs1 + off;
      nb           = 1 << rq.size;
      unsg         = rq.unsign;
      e.inst_type  = (rq.op == lsc_pkg::op_store);
      e.store_data = rq.rs2;
    end
    last = a + nb - 1;
    in_d = (a >= `LSC_DCCM_BASE) && (a - `LSC_DCCM_BASE < `LSC_DCCM_SIZE);
    in_p = (a >= `LSC_PIC_BASE) && (a - `LSC_PIC_BASE < `LSC_PIC_SIZE);
    mis  = ((a & (nb - 1)) != 0) && !in_d;
    af   = (in_d != ((last >= `LSC_DCCM_BASE) && (last - `LSC_DCCM_BASE < `LSC_DCCM_SIZE))) ||
           (in_p != ((last >= `LSC_PIC_BASE) && (last - `LSC_PIC_BASE < `LSC_PIC_SIZE))) ||
           (in_p && nb != 4);
    raw = (in_d || in_p) ? ld : bus;
    sh  = 32 - 8 * nb;
    if (unsg) begin
      e.result = (raw << sh) >> sh;
    end else begin
      e.result = $signed(raw << sh) >>> sh;
    end
    e.addr       = a;
    e.is_load    = core & (rq.op == lsc_pkg::op_load);
    e.exc_dc2    = (dq.req | (core & ~kv[0] & ~kv[1])) & (mis | af);
    e.exc_valid  = core & ~|kv[3:0] & (mis | af | berr);
    e.exc_type   = ~mis;
    e.dma_valid  = dq.req;
    e.commit     = core & ~|kv;
    e.chk_dc5    = e.commit | dq.req;
    model_access = e;
  endfunction

  function automatic exp_t exp_at(input int i);
    if (i < 0) begin
      exp_at = '0;
    end else begin
      exp_at = exp_m[i];
    end
  endfunction

  // **********************************************************************
  // Stimulus
  // **********************************************************************

  task automatic build_stimulus();
    logic [31:0] a;
    logic [11:0] off;
    int          kind;
    for (int i = 0; i < N_MEM; i++) begin
      iss_m[i]        = '0;
      dma_m[i]        = '0;
      fl_m[i]         = '0;
      ld_m[i]         = $random(seed);
      bus_m[i]        = $random(seed);
      berr_m[i]       = 1'b0;
      a               = $random(seed);
      off             = $random(seed);
      kind            = pick(4);
      iss_m[i].rs2    = $random(seed);
      iss_m[i].op     = lsc_pkg::lsu_op_e'(pick(2));
      iss_m[i].size   = lsc_pkg::lsu_size_e'(pick(3));
      iss_m[i].unsign = pick(2);
      if (i < 8 || i >= N_CYC - 8) begin
        // Idle slots around reset and while draining
        iss_m[i].valid = 1'b0;
      end else if (i < 68) begin
        iss_m[i].valid = pick(8) != 0;
        iss_m[i].op    = lsc_pkg::op_load;
        a = `LSC_DCCM_BASE + pick(`LSC_DCCM_SIZE - 4);
      end else if (i < 128) begin
        iss_m[i].valid = pick(8) != 0;
        iss_m[i].op    = lsc_pkg::op_load;
        a = {1'b0, a[30:0]} & ~((32'd1 << iss_m[i].size) - 32'd1);
        berr_m[i] = pick(4) == 0;
      end else if (i < 188) begin
        iss_m[i].valid = 1'b1;
        case (kind)
          0: begin
            iss_m[i].size = pick(2) ? lsc_pkg::sz_half : lsc_pkg::sz_word;
            a = {1'b0, a[30:1], 1'b1};
          end
          1: begin
            iss_m[i].size = lsc_pkg::sz_byte;
            a = `LSC_PIC_BASE + pick(`LSC_PIC_SIZE);
          end
          2: begin
            iss_m[i].size = lsc_pkg::sz_word;
            a = `LSC_DCCM_BASE + `LSC_DCCM_SIZE - 1 - pick(3);
          end
          default: begin
            iss_m[i].size = lsc_pkg::sz_word;
            a = `LSC_PIC_BASE + (pick(`LSC_PIC_SIZE) & ~3);
          end
        endcase
      end else begin
        iss_m[i].valid = pick(4) != 0;
        if (kind[0]) begin
          a = `LSC_DCCM_BASE + pick(`LSC_DCCM_SIZE - 4);
        end else begin
          a = {1'b0, a[30:0]} & ~((32'd1 << iss_m[i].size) - 32'd1);
        end
        fl_m[i] = {pick(6) == 0, pick(6) == 0, pick(6) == 0, pick(6) == 0};
        // DMA mixed in over the last stretch
        if (i >= 268) begin
          dma_m[i].req   = pick(2);
          dma_m[i].addr  = a;
          dma_m[i].sz    = pick(4);
          dma_m[i].write = pick(2);
          dma_m[i].wdata = $random(seed);
          berr_m[i]      = pick(4) == 0;
        end
      end
      iss_m[i].offset = off;
      iss_m[i].rs1    = a - int'($signed(off));
    end
  endtask

  task automatic build_expectations();
    logic [5:0] kv;
    for (int t = 0; t < N_CYC; t++) begin
      kv = {fl_m[t+5].flush_dc5, fl_m[t+4].flush_dc4, fl_m[t+3].flush_dc3,
            fl_m[t+2].flush_dc2_up, fl_m[t+1].flush_dc2_up, fl_m[t].flush_dc2_up};
      exp_m[t] = model_access(iss_m[t], dma_m[t], ld_m[t], bus_m[t], berr_m[t], kv);
    end
  endtask

  // dc3 read data follows the access issued three cycles earlier
  task automatic drive_cycle(input int c);
    issue = iss_m[c];
    dma   = dma_m[c];
    flush = fl_m[c];
    if (c >= 3) begin
      ld_data_dc3       = ld_m[c-3];
      bus_read_data_dc3 = bus_m[c-3];
      ld_bus_error_dc3  = berr_m[c-3];
    end else begin
      ld_data_dc3       = '0;
      bus_read_data_dc3 = '0;
      ld_bus_error_dc3  = 1'b0;
    end
  endtask

  // **********************************************************************
  // Checking
  // **********************************************************************

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    n_checks++;
    if (got !== want) begin
      n_val_err++;
      $display("Fail: time %0t, %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic print_counts();
    $display("Checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
             n_checks, n_val_err, n_other_err, u_dut.u_chk.assert_fails);
  endtask

  // Outputs are stable half a cycle after the inputs change
  always @(negedge clk) begin
    if (!rst_n) begin
      check_val("lsu_commit_dc5", lsu_commit_dc5, 32'd0);
      check_val("lsu_exc_dc2", lsu_exc_dc2, 32'd0);
      check_val("exc_valid", lsu_error_pkt_dc3.exc_valid, 32'd0);
    end else if (running) begin
      e1 = exp_at(cyc - 1);
      e2 = exp_at(cyc - 2);
      e3 = exp_at(cyc - 3);
      e5 = exp_at(cyc - 5);
      if (cyc >= 1) begin
        check_val("lsu_addr_dc1", lsu_addr_dc1, e1.addr);
      end
      check_val("lsu_exc_dc2", lsu_exc_dc2, e2.exc_dc2);
      if (e3.is_load) begin
        check_val("lsu_result_dc3", lsu_result_dc3, e3.result);
      end
      check_val("exc_valid", lsu_error_pkt_dc3.exc_valid, e3.exc_valid);
      check_val("dma_valid", lsu_error_pkt_dc3.dma_valid, e3.dma_valid);
      if (e3.exc_valid) begin
        check_val("exc_type", lsu_error_pkt_dc3.exc_type, e3.exc_type);
        check_val("inst_type", lsu_error_pkt_dc3.inst_type, e3.inst_type);
        check_val("error addr", lsu_error_pkt_dc3.addr, e3.addr);
      end
      check_val("lsu_commit_dc5", lsu_commit_dc5, e5.commit);
      if (e5.chk_dc5) begin
        check_val("lsu_addr_dc5", lsu_addr_dc5, e5.addr);
        check_val("store_data_dc5", store_data_dc5, e5.store_data);
      end
    end
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= LIMIT_CYC);
    $display("Timeout: the run did not finish within %0d cycles", LIMIT_CYC);
    n_other_err++;
    print_counts();
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    seed              = 32'h98d5;
    n_checks          = 0;
    n_val_err         = 0;
    n_other_err       = 0;
    running           = 1'b0;
    cyc               = 0;
    rst_n             = 1'b0;
    issue             = '0;
    dma               = '0;
    flush             = '0;
    ld_data_dc3       = '0;
    bus_read_data_dc3 = '0;
    ld_bus_error_dc3  = 1'b0;
    build_stimulus();
    build_expectations();
    repeat (3) @(posedge clk);
    #1;
    rst_n   = 1'b1;
    running = 1'b1;
    for (int c = 0; c < N_CYC; c++) begin
      cyc = c;
      drive_cycle(c);
      @(posedge clk);
      #1;
    end
    running = 1'b0;
    print_counts();
    if (n_val_err + n_other_err + u_dut.u_chk.assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
